// ==== all.f ====
+incdir+include
logic/div_pkg.sv
logic/div_operand_prep.sv
logic/div_step_counter.sv
logic/div_ctrl_fsm.sv
logic/div_shift_sub.sv
logic/div_result_format.sv
logic/div_top.sv
testbench/div_checker.sv
testbench/div_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = div_tb
FILELIST  = all.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: compile run clean

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES) include/div_config.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/div_tb.sv ====
// Testbench for the divider with credit-driven requests, a reference model and a scoreboard.
// Runs from the Makefile and ends with a pass or fail line.
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_tb
  import div_pkg::*;
();

  localparam int GRANT_PERIOD = 1500; // credit pattern repeats
  localparam int WITHHOLD_LEN = 500;  // no grants at start of each period
  localparam int N_RANDOM     = 300;

  logic    clk, rst_n, req_valid_i, result_credit_i;
  logic    req_credit_o, result_valid_o;
  div_op_e req_op_i;
  xlen_t   dividend_i, divisor_i, result_o;

  int      seed = 41;
  int      total, done_cnt, granted_cnt, returned_cnt;
  int      timeout_limit;
  int      cycle_cnt = 0;
  div_op_e stim_op[$];
  xlen_t   stim_a[$], stim_b[$], exp_q[$];

  div_top i_div_top (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid_i),
    .req_op_i        (req_op_i),
    .dividend_i      (dividend_i),
    .divisor_i       (divisor_i),
    .req_credit_o    (req_credit_o),
    .result_credit_i (result_credit_i),
    .result_valid_o  (result_valid_o),
    .result_o        (result_o)
  );

  bind div_top div_checker i_div_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid_i),
    .result_credit_i (result_credit_i),
    .result_valid_i  (result_valid_o),
    .req_credit_i    (req_credit_o)
  );

  always #20 clk = ~clk;

  // ============================================================
  // reference model
  // ============================================================
  function automatic xlen_t ref_result(input div_op_e op, input xlen_t a, input xlen_t b);
    logic signed [63:0] sa, sb;
    logic signed [31:0] wa, wb;
    logic [31:0]        ua, ub, w;
    xlen_t              res;
    sa  = a;
    sb  = b;
    wa  = a[31:0];
    wb  = b[31:0];
    ua  = a[31:0];
    ub  = b[31:0];
    w   = '0;
    res = '0;
    case (op)
      OP_DIV: begin
        if (b == '0) res = '1;
        else if (a == 64'h8000_0000_0000_0000 && b == '1) res = a; // overflow
        else res = sa / sb;
      end
      OP_DIVU: res = (b == '0) ? '1 : a / b;
      OP_REM: begin
        if (b == '0) res = a;
        else if (a == 64'h8000_0000_0000_0000 && b == '1) res = '0;
        else res = sa % sb;
      end
      OP_REMU: res = (b == '0) ? a : a % b;
      OP_DIVW: begin
        if (ub == '0) w = '1;
        else if (ua == 32'h8000_0000 && ub == '1) w = ua;
        else w = wa / wb;
      end
      OP_DIVUW: w = (ub == '0) ? '1 : ua / ub;
      OP_REMW: begin
        if (ub == '0) w = ua;
        else if (ua == 32'h8000_0000 && ub == '1) w = '0;
        else w = wa % wb;
      end
      default: w = (ub == '0) ? ua : ua % ub; // remuw
    endcase
    if (op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW}) begin
      res = {{32{w[31]}}, w};
    end
    return res;
  endfunction

  // ============================================================
  // stimulus
  // ============================================================
  task automatic add_req(input div_op_e op, input xlen_t a, input xlen_t b);
    stim_op.push_back(op);
    stim_a.push_back(a);
    stim_b.push_back(b);
  endtask

  task automatic add_sign_combos(input div_op_e op, input xlen_t a, input xlen_t b);
    add_req(op, a, b);
    add_req(op, -a, b);
    add_req(op, a, -b);
    add_req(op, -a, -b);
  endtask

  task automatic build_stimulus;
    div_op_e ops_d[4];
    div_op_e ops_w[4];
    xlen_t   b;
    int      i, r;
    ops_d = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    ops_w = '{OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
    for (i = 0; i < 4; i++) begin
      add_sign_combos(ops_d[i], 64'd1000003, 64'd17);
      add_sign_combos(ops_d[i], 64'h7fff_ffff_ffff_fff1, 64'd3);
      add_sign_combos(ops_d[i], 64'd5, 64'h0000_0100_0000_0007); // quotient zero
      add_sign_combos(ops_w[i], {32'hdead_beef, 32'd1000003}, {32'h1234_5678, 32'd17});
      add_sign_combos(ops_w[i], {32'hffff_0000, 32'h7fff_fff1}, {32'h0bad_f00d, 32'd3});
      add_req(ops_d[i], 64'hfedc_ba98_7654_3210, '0);
      add_req(ops_w[i], {32'hcafe_f00d, 32'h8765_4321}, {32'habcd_0123, 32'h0});
      add_req(ops_d[i], 64'h8000_0000_0000_0000, '1);
      add_req(ops_w[i], {32'h1357_9bdf, 32'h8000_0000}, {32'h2468_ace0, 32'hffff_ffff});
    end
    for (i = 0; i < N_RANDOM; i++) begin
      r = $random(seed);
      case (r[5:4])
        2'd0:    b = {$random(seed), $random(seed)};
        2'd1:    b = xlen_t'(r[15:8]) + xlen_t'(1);    // small positive
        2'd2:    b = -(xlen_t'(r[15:8]) + xlen_t'(1)); // small negative
        default: b = {$random(seed), 32'h0};           // word divisor zero
      endcase
      add_req(div_op_e'(r[2:0]), {$random(seed), $random(seed)}, b);
    end
  endtask

  // one request credit, regained on each req_credit_o pulse
  task automatic send_requests;
    int i;
    for (i = 0; i < total; i++) begin
      while (1 + returned_cnt - i <= 0) begin
        @(posedge clk);
        #1;
      end
      req_valid_i = 1'b1;
      req_op_i    = stim_op[i];
      dividend_i  = stim_a[i];
      divisor_i   = stim_b[i];
      exp_q.push_back(ref_result(stim_op[i], stim_a[i], stim_b[i]));
      @(posedge clk);
      #1;
      req_valid_i = 1'b0;
    end
  endtask

  task automatic grant_credits;
    int cyc;
    int r;
    cyc = 0;
    while (done_cnt < total) begin
      r = $random(seed);
      if ((cyc % GRANT_PERIOD) >= WITHHOLD_LEN &&
          (granted_cnt - done_cnt) < `DIV_RESULT_CREDITS && r[1:0] == 2'd0) begin
        result_credit_i = 1'b1;
        @(posedge clk);
        granted_cnt++; // counted on the edge the DUT sees it
        #1 result_credit_i = 1'b0;
      end else begin
        @(posedge clk);
        #1;
      end
      cyc++;
    end
  endtask

  // ============================================================
  // checking
  // ============================================================
  task automatic check_value(input xlen_t got, input xlen_t expected, input string what);
    if (got !== expected) begin
      $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, expected);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_results;
    xlen_t expected;
    while (done_cnt < total) begin
      @(negedge clk); // outputs settled mid-cycle
      check_value(xlen_t'(req_credit_o), xlen_t'(result_valid_o), "request credit vs result");
      if (req_credit_o) begin
        returned_cnt++;
      end
      if (result_valid_o) begin
        check_value(xlen_t'(granted_cnt > done_cnt), xlen_t'(1), "result credit held at issue");
        check_value(xlen_t'(exp_q.size() != 0), xlen_t'(1), "request pending at result");
        expected = exp_q.pop_front();
        check_value(result_o, expected,
                    $sformatf("%s result %0d", stim_op[done_cnt].name(), done_cnt));
        done_cnt++;
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > timeout_limit) begin
      $display("timeout, the run did not finish within %0d cycles", timeout_limit);
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b1;
    req_valid_i     = 1'b0;
    req_op_i        = OP_DIV;
    dividend_i      = '0;
    divisor_i       = '0;
    result_credit_i = 1'b0;
    done_cnt        = 0;
    granted_cnt     = 0;
    returned_cnt    = 0;
    build_stimulus();
    total = stim_op.size();
    // 70 cycles per request plus the withheld share of each period
    timeout_limit = total * 70 + total * 70 * WITHHOLD_LEN / (GRANT_PERIOD - WITHHOLD_LEN) + 2000;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b0;
    fork
      send_requests();
      compare_results();
      grant_credits();
    join
    if (exp_q.size() == 0 && done_cnt == total) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("run ended with %0d of %0d results checked", done_cnt, total);
      $display("SIMULATION FAILED");
      $fatal(1, "incomplete run");
    end
  end

endmodule

`default_nettype wire

// ==== testbench/div_checker.sv ====
// Handshake and credit assertions, bound onto the divider top level.
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_checker
  import div_pkg::*;
(
  input logic clk,
  input logic rst_n,
  input logic req_valid_i,
  input logic result_credit_i,
  input logic result_valid_i,
  input logic req_credit_i
);

  localparam credit_cnt_t MAX_CREDITS = credit_cnt_t'(`DIV_RESULT_CREDITS);

  logic        busy_q;
  credit_cnt_t credit_q;
  logic        reset_seen_q = 1'b0; // one reset edge seen

  always @(posedge clk) begin
    reset_seen_q <= rst_n;
    if (rst_n) begin
      busy_q   <= 1'b0;
      credit_q <= '0;
    end else begin
      if (req_valid_i) begin
        busy_q <= 1'b1;
      end else if (result_valid_i) begin
        busy_q <= 1'b0;
      end
      if (result_credit_i && !result_valid_i && credit_q != MAX_CREDITS) begin
        credit_q <= credit_q + credit_cnt_t'(1);
      end else if (!result_credit_i && result_valid_i) begin
        credit_q <= credit_q - credit_cnt_t'(1);
      end
    end
  end

  a_no_request_when_busy: assert property (@(posedge clk) disable iff (rst_n)
    req_valid_i |-> !busy_q) else $error("request sent while divider busy");

  a_result_needs_credit: assert property (@(posedge clk) disable iff (rst_n)
    result_valid_i |-> credit_q != '0) else $error("result issued with no credit");

  a_credit_with_result: assert property (@(posedge clk) disable iff (rst_n)
    result_valid_i == req_credit_i) else $error("request credit and result out of step");

  a_quiet_in_reset: assert property (@(posedge clk)
    (reset_seen_q && rst_n) |-> (!result_valid_i && !req_credit_i))
    else $error("outputs active during reset");

endmodule

`default_nettype wire

// ==== logic/div_top.sv ====
// Top level of the iterative divider, one operation in flight.
// Credit-based handshake on both the request and the result side.
`timescale 1ns/1ps
`default_nettype none

module div_top
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    req_valid_i,
  input  div_op_e req_op_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  output logic    req_credit_o,
  input  logic    result_credit_i,
  output logic    result_valid_o,
  output xlen_t   result_o
);

  xlen_t     dividend_mag, divisor_mag;
  xlen_t     special_val;
  step_cnt_t steps;
  dword_t    rq;
  logic      quot_neg, rem_neg, special;
  logic      load, step, last_step;

  div_operand_prep i_div_operand_prep (
    .op_i           (req_op_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .dividend_mag_o (dividend_mag),
    .divisor_mag_o  (divisor_mag),
    .steps_o        (steps),
    .quot_neg_o     (quot_neg),
    .rem_neg_o      (rem_neg),
    .special_o      (special),
    .special_val_o  (special_val)
  );

  div_step_counter i_div_step_counter (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_i      (load),
    .step_i      (step),
    .steps_i     (steps),
    .last_step_o (last_step)
  );

  div_ctrl_fsm i_div_ctrl_fsm (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_valid_i     (req_valid_i),
    .special_i       (special),
    .last_step_i     (last_step),
    .result_credit_i (result_credit_i),
    .load_o          (load),
    .step_o          (step),
    .result_valid_o  (result_valid_o),
    .req_credit_o    (req_credit_o)
  );

  div_shift_sub i_div_shift_sub (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_i         (load),
    .step_i         (step),
    .dividend_mag_i (dividend_mag),
    .divisor_mag_i  (divisor_mag),
    .rq_o           (rq)
  );

  div_result_format i_div_result_format (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_i        (load),
    .op_i          (req_op_i),
    .quot_neg_i    (quot_neg),
    .rem_neg_i     (rem_neg),
    .special_i     (special),
    .special_val_i (special_val),
    .rq_i          (rq),
    .result_o      (result_o)
  );

endmodule

`default_nettype wire

// ==== logic/div_result_format.sv ====
// Latches sign and special info at accept, then builds the final result.
`timescale 1ns/1ps
`default_nettype none

module div_result_format
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    load_i,
  input  div_op_e op_i,
  input  logic    quot_neg_i,
  input  logic    rem_neg_i,
  input  logic    special_i,
  input  xlen_t   special_val_i,
  input  dword_t  rq_i,
  output xlen_t   result_o
);

  localparam int X = $bits(xlen_t);
  localparam int H = X / 2;

  div_op_e op_q;
  logic    quot_neg_q, rem_neg_q, special_q;
  xlen_t   special_val_q;
  xlen_t   quot, rem, sel;
  logic    is_word, is_rem;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      op_q          <= OP_DIV;
      quot_neg_q    <= 1'b0;
      rem_neg_q     <= 1'b0;
      special_q     <= 1'b0;
      special_val_q <= '0;
    end else if (load_i) begin
      op_q          <= op_i;
      quot_neg_q    <= quot_neg_i;
      rem_neg_q     <= rem_neg_i;
      special_q     <= special_i;
      special_val_q <= special_val_i; // already extended
    end
  end

  assign is_word = op_q inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  assign is_rem  = op_q inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};

  assign quot = quot_neg_q ? (~rq_i[X-1:0] + xlen_t'(1)) : rq_i[X-1:0];
  assign rem  = rem_neg_q ? (~rq_i[2*X-1:X] + xlen_t'(1)) : rq_i[2*X-1:X];
  assign sel  = is_rem ? rem : quot;

  assign result_o = special_q ? special_val_q
                  : is_word   ? {{H{sel[H-1]}}, sel[H-1:0]}
                  :             sel;

endmodule

`default_nettype wire

// ==== logic/div_shift_sub.sv ====
// Remainder:quotient register with one restoring step per clock.
// Loaded with the dividend magnitude, holds the divisor magnitude.
`timescale 1ns/1ps
`default_nettype none

module div_shift_sub
  import div_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   load_i,
  input  logic   step_i,
  input  xlen_t  dividend_mag_i,
  input  xlen_t  divisor_mag_i,
  output dword_t rq_o
);

  localparam int X = $bits(xlen_t);

  dword_t         rq_q;
  xlen_t          divisor_q;
  logic [X+1:0]   diff;     // shifted remainder keeps its carry bit
  logic           fits;

  // top X+1 bits of rq_q are the remainder after the left shift
  assign diff = {1'b0, rq_q[2*X-1:X-1]} - {2'b00, divisor_q};
  assign fits = !diff[X+1];

  always_ff @(posedge clk) begin
    if (rst_n) begin
      rq_q      <= '0;
      divisor_q <= '0;
    end else if (load_i) begin
      rq_q      <= {{X{1'b0}}, dividend_mag_i};
      divisor_q <= divisor_mag_i;
    end else if (step_i) begin
      if (fits) begin
        rq_q <= {diff[X-1:0], rq_q[X-2:0], 1'b1}; // keep difference
      end else begin
        rq_q <= {rq_q[2*X-2:0], 1'b0};            // restore
      end
    end
  end

  assign rq_o = rq_q;

endmodule

`default_nettype wire

// ==== logic/div_ctrl_fsm.sv ====
// Sequences accept, iterate and issue for one division at a time.
// Holds the result credit count and hands the request credit back.
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_ctrl_fsm
  import div_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic req_valid_i,
  input  logic special_i,
  input  logic last_step_i,
  input  logic result_credit_i,
  output logic load_o,
  output logic step_o,
  output logic result_valid_o,
  output logic req_credit_o
);

  localparam credit_cnt_t MAX_CREDITS = credit_cnt_t'(`DIV_RESULT_CREDITS);

  div_state_e  state_q, state_d;
  credit_cnt_t credit_q;
  logic        issue;

  // ============================================================
  // state machine
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (req_valid_i) begin
          state_d = special_i ? S_DONE : S_ITER; // special skips the loop
        end
      end
      S_ITER: begin
        if (last_step_i) begin
          state_d = S_DONE;
        end
      end
      S_DONE: begin
        if (issue) begin
          state_d = S_IDLE;
        end
      end
      default: state_d = S_IDLE;
    endcase
  end

  assign load_o = (state_q == S_IDLE) && req_valid_i;
  assign step_o = (state_q == S_ITER);
  assign issue  = (state_q == S_DONE) && (credit_q != '0);

  assign result_valid_o = issue;
  assign req_credit_o   = issue; // credit goes back with the result

  // ============================================================
  // result credits
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      credit_q <= '0;
    end else begin
      case ({result_credit_i, issue})
        2'b10: begin
          if (credit_q != MAX_CREDITS) begin
            credit_q <= credit_q + credit_cnt_t'(1);
          end
        end
        2'b01:   credit_q <= credit_q - credit_cnt_t'(1);
        default: credit_q <= credit_q; // grant and spend cancel
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/div_step_counter.sv ====
// Counts the remaining divide steps and flags the final one.
`timescale 1ns/1ps
`default_nettype none

module div_step_counter
  import div_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      load_i,
  input  logic      step_i,
  input  step_cnt_t steps_i,
  output logic      last_step_o
);

  step_cnt_t cnt_q;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= steps_i; // 64 or 32
    end else if (step_i) begin
      cnt_q <= cnt_q - step_cnt_t'(1);
    end
  end

  assign last_step_o = (cnt_q == step_cnt_t'(1)); // step in flight is the last

endmodule

`default_nettype wire

// ==== logic/div_operand_prep.sv ====
// Turns a raw request into magnitudes, sign flags and step count.
// Also flags divide-by-zero and signed overflow with the ISA result.
`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module div_operand_prep
  import div_pkg::*;
(
  input  div_op_e   op_i,
  input  xlen_t     dividend_i,
  input  xlen_t     divisor_i,
  output xlen_t     dividend_mag_o,
  output xlen_t     divisor_mag_o,
  output step_cnt_t steps_o,
  output logic      quot_neg_o,
  output logic      rem_neg_o,
  output logic      special_o,
  output xlen_t     special_val_o
);

  localparam int X = `DIV_XLEN;
  localparam int H = `DIV_XLEN / 2;

  localparam xlen_t MIN_D = {1'b1, {(X-1){1'b0}}};          // -2^63
  localparam xlen_t MIN_W = {{(H+1){1'b1}}, {(H-1){1'b0}}}; // sext(-2^31)

  logic  is_word, is_uns, is_rem;
  logic  a_neg, b_neg;
  logic  div_zero, div_ovf;
  xlen_t a_sext, b_sext;
  xlen_t a_ext, b_ext;
  xlen_t a_abs, b_abs;
  xlen_t a_res;

  assign is_word = op_i inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  assign is_uns  = op_i inside {OP_DIVU, OP_DIVUW, OP_REMU, OP_REMUW};
  assign is_rem  = op_i inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};

  // ============================================================
  // width and sign extension
  // ============================================================
  assign a_sext = {{H{dividend_i[H-1]}}, dividend_i[H-1:0]};
  assign b_sext = {{H{divisor_i[H-1]}}, divisor_i[H-1:0]};

  always_comb begin
    if (!is_word) begin
      a_ext = dividend_i;
      b_ext = divisor_i;
    end else if (is_uns) begin
      a_ext = {{H{1'b0}}, dividend_i[H-1:0]}; // upper garbage dropped
      b_ext = {{H{1'b0}}, divisor_i[H-1:0]};
    end else begin
      a_ext = a_sext;
      b_ext = b_sext;
    end
  end

  assign a_neg = !is_uns && a_ext[X-1];
  assign b_neg = !is_uns && b_ext[X-1];
  assign a_abs = a_neg ? (~a_ext + xlen_t'(1)) : a_ext;
  assign b_abs = b_neg ? (~b_ext + xlen_t'(1)) : b_ext;

  // word dividend sits high so 32 steps shift it all out
  assign dividend_mag_o = is_word ? {a_abs[H-1:0], {H{1'b0}}} : a_abs;
  assign divisor_mag_o  = b_abs;
  assign steps_o        = is_word ? step_cnt_t'(H) : step_cnt_t'(X);
  assign quot_neg_o     = a_neg ^ b_neg;
  assign rem_neg_o      = a_neg; // remainder follows dividend

  // ============================================================
  // special cases
  // ============================================================
  assign div_zero = (b_ext == '0);
  assign div_ovf  = !is_uns && (b_ext == '1) && (a_ext == (is_word ? MIN_W : MIN_D));
  assign a_res    = is_word ? a_sext : dividend_i;

  assign special_o     = div_zero || div_ovf;
  assign special_val_o = is_rem ? (div_zero ? a_res : '0)  // rem by -1 gives zero
                                : (div_zero ? '1 : a_res); // quotient all ones

endmodule

`default_nettype wire

// ==== logic/div_pkg.sv ====
// Shared types for the divider blocks and the testbench.
// Import with a wildcard in the module header.
`default_nettype none

`include "div_config.svh"

package div_pkg;

  typedef logic [`DIV_XLEN-1:0]       xlen_t;     // one operand or result
  typedef logic [2*`DIV_XLEN-1:0]     dword_t;    // remainder:quotient
  typedef logic [`DIV_STEP_CNT_W-1:0] step_cnt_t; // remaining steps

  typedef logic [$clog2(`DIV_RESULT_CREDITS+1)-1:0] credit_cnt_t;

  // bit 2 rem, bit 1 word, bit 0 unsigned
  typedef enum logic [2:0] {
    OP_DIV   = 3'd0,
    OP_DIVU  = 3'd1,
    OP_DIVW  = 3'd2,
    OP_DIVUW = 3'd3,
    OP_REM   = 3'd4,
    OP_REMU  = 3'd5,
    OP_REMW  = 3'd6,
    OP_REMUW = 3'd7
  } div_op_e;

  typedef enum logic [1:0] {
    S_IDLE = 2'd0,
    S_ITER = 2'd1,
    S_DONE = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

// ==== include/div_config.svh ====
// Fixed widths and credit depth for the RV64 M-extension divider.
// Include wherever one of these macros is referenced.
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// ============================================================
// datapath
// ============================================================
`define DIV_XLEN 64 // register width of the core

// iteration counter must hold DIV_XLEN itself
`define DIV_STEP_CNT_W 7

// ============================================================
// flow control
// ============================================================
// most result credits the consumer may hand out at once
`define DIV_RESULT_CREDITS 4

`endif
